//--- design/int_pkg.sv
package int_pkg;

  // Address and data path width.
  localparam int addr_w = 32;

  // Vector number width.
  localparam int vec_w = 8;

  localparam int sel_w = 16;  // Code segment selector.

  // Gate entry is two words.
  localparam int gate_bytes = 8;
  localparam int hi_word = 4;  // Byte offset of the selector word.

  // Codes 010 and 110 are unused and fall back to IDLE.
  typedef enum logic [2:0] {
    IDLE    = 3'b000,
    FLUSH   = 3'b001,
    CAPTURE = 3'b100,
    READ_LO = 3'b011,
    READ_HI = 3'b101,
    LOAD    = 3'b111
  } int_state_t;

  // One bit per pipeline stage, fetch first.
  typedef struct packed {
    logic fetch;
    logic dec_0;
    logic dec_1;
    logic reg_rd;
    logic addr;
    logic ex;
    logic wb;
  } flush_t;

  typedef struct packed {
    logic [addr_w-1:0] offset;   // Low word of the gate.
    logic [sel_w-1:0]  selector; // High word, bits 15:0.
  } gate_t;

  // Return point of the interrupted code.
  typedef struct packed {
    logic [addr_w-1:0] eip;
    logic [sel_w-1:0]  cs;
  } frame_t;

  localparam flush_t flush_none = '0;
  localparam flush_t flush_all = '1;

endpackage

//--- design/int_pending.sv
`timescale 1ns/1ps

module int_pending #(
  parameter int NUM_LINES = 8,
  parameter int VEC_BASE  = 32
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic [NUM_LINES-1:0]      int_line,
  input  logic                      int_clear,
  input  logic                      lock,
  output logic                      pending,
  output logic [int_pkg::vec_w-1:0] vector,
  output logic [NUM_LINES-1:0]      line_sel
);

  import int_pkg::*;

  logic [NUM_LINES-1:0] pend_q;
  logic [NUM_LINES-1:0] sel_q;
  logic [NUM_LINES-1:0] pri_sel;
  logic [NUM_LINES-1:0] clr_mask;
  logic [vec_w-1:0]     line_idx;

  // Lowest set bit wins.
  assign pri_sel = pend_q & (~pend_q + NUM_LINES'(1));

  assign line_sel = lock ? sel_q : pri_sel; // Frozen for the whole entry.
  assign pending = |pend_q;
  assign clr_mask = int_clear ? sel_q : '0;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pend_q <= '0;
      sel_q  <= '0;
    end else begin
      // A line still held high sets its bit again.
      pend_q <= (pend_q & ~clr_mask) | int_line;
      if (!lock) begin
        sel_q <= pri_sel;
      end
    end
  end

  always_comb begin
    line_idx = '0;
    for (int i = 0; i < NUM_LINES; i++) begin
      if (line_sel[i]) begin
        line_idx = vec_w'(i);
      end
    end
  end

  assign vector = vec_w'(VEC_BASE) + line_idx;

  a_sel_onehot: assert property (@(posedge clk) disable iff (!rst_n)
    pending |-> $onehot(line_sel));

endmodule

//--- design/int_seq_ctrl.sv
`timescale 1ns/1ps

module int_seq_ctrl (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            pending,
  input  logic            mem_ready,
  output int_pkg::flush_t flush,
  output logic            mem_valid,
  output logic            addrp1,
  output logic            capture_bottom_eip,
  output logic            reg_load_cs,
  output logic            fetch_load,
  output logic            int_clear,
  output logic            busy
);

  import int_pkg::*;

  int_state_t state_q;
  int_state_t state_d;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (pending) begin
          state_d = FLUSH;
        end
      end
      FLUSH:   state_d = CAPTURE;
      CAPTURE: state_d = READ_LO;
      READ_LO: begin
        if (mem_ready) begin
          state_d = READ_HI;
        end
      end
      READ_HI: begin
        if (mem_ready) begin
          state_d = LOAD;
        end
      end
      LOAD:    state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  // Output decode, current state only.
  always_comb begin
    flush              = flush_none;
    mem_valid          = 1'b0;
    addrp1             = 1'b0;
    capture_bottom_eip = 1'b0;
    reg_load_cs        = 1'b0;
    fetch_load         = 1'b0;
    int_clear          = 1'b0;
    busy               = 1'b0;
    case (state_q)
      FLUSH: begin
        flush = flush_all;
        busy  = 1'b1;
      end
      CAPTURE: begin
        flush.fetch        = 1'b1;
        capture_bottom_eip = 1'b1;
        busy               = 1'b1;
      end
      READ_LO: begin
        flush.fetch = 1'b1; // Keep fetch quiet during the gate reads.
        mem_valid   = 1'b1;
        busy        = 1'b1;
      end
      READ_HI: begin
        flush.fetch = 1'b1;
        mem_valid   = 1'b1;
        addrp1      = 1'b1;
        busy        = 1'b1;
      end
      LOAD: begin
        fetch_load  = 1'b1;
        reg_load_cs = 1'b1;
        int_clear   = 1'b1;
        busy        = 1'b1;
      end
      default: begin
        busy = 1'b0;  // IDLE and the spare codes.
      end
    endcase
  end

  a_load_after_hi: assert property (@(posedge clk) disable iff (!rst_n)
    fetch_load |-> $past(state_q) == READ_HI);

  // First busy cycle is the full flush, with no memory request.
  a_no_mem_in_flush: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(busy) |-> flush == flush_all && !mem_valid);

endmodule

//--- design/int_frame_unit.sv
`timescale 1ns/1ps

module int_frame_unit #(
  parameter logic [int_pkg::addr_w-1:0] IDT_BASE = 32'h0000_1000
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic [int_pkg::vec_w-1:0]  vector,
  input  logic                       mem_valid,
  input  logic                       addrp1,
  input  logic                       mem_ready,
  input  logic [int_pkg::addr_w-1:0] mem_rdata,
  input  logic                       capture_bottom_eip,
  input  logic [int_pkg::addr_w-1:0] bottom_eip,
  input  logic [int_pkg::sel_w-1:0]  cur_cs,
  input  logic                       reg_load_cs,
  output logic [int_pkg::addr_w-1:0] mem_addr,
  output logic [int_pkg::addr_w-1:0] new_eip,
  output logic [int_pkg::sel_w-1:0]  new_cs,
  output int_pkg::frame_t            ret_frame
);

  import int_pkg::*;

  gate_t             gate_q;
  logic [addr_w-1:0] eip_q;
  logic [sel_w-1:0]  cs_q;
  logic              xfer;

  // Gate sits at IDT_BASE + vector * 8, selector word 4 bytes on.
  assign mem_addr = IDT_BASE + addr_w'(vector) * addr_w'(gate_bytes)
                  + (addrp1 ? addr_w'(hi_word) : '0);

  assign xfer = mem_valid && mem_ready;

  always_ff @(posedge clk) begin
    if (xfer) begin
      if (addrp1) begin
        gate_q.selector <= mem_rdata[sel_w-1:0];
      end else begin
        gate_q.offset <= mem_rdata;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (capture_bottom_eip) begin
      ret_frame.eip <= bottom_eip;
      ret_frame.cs  <= cur_cs;
    end
  end

  // Fetch target, held after the load cycle.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      eip_q <= '0;
      cs_q  <= '0;
    end else if (reg_load_cs) begin
      eip_q <= gate_q.offset;
      cs_q  <= gate_q.selector;
    end
  end

  // Gate goes straight out in the load cycle itself.
  assign new_eip = reg_load_cs ? gate_q.offset : eip_q;
  assign new_cs = reg_load_cs ? gate_q.selector : cs_q;

  a_addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (mem_valid && !mem_ready) |=> (mem_valid && $stable(mem_addr)));

endmodule

//--- design/int_entry.sv
`timescale 1ns/1ps

module int_entry #(
  parameter int                         NUM_LINES = 8,
  parameter int                         VEC_BASE  = 32,
  parameter logic [int_pkg::addr_w-1:0] IDT_BASE  = 32'h0000_1000
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic [NUM_LINES-1:0]       int_line,
  input  logic [int_pkg::addr_w-1:0] bottom_eip,
  input  logic [int_pkg::sel_w-1:0]  cur_cs,
  input  logic [int_pkg::addr_w-1:0] mem_rdata,
  input  logic                       mem_ready,
  output int_pkg::flush_t            flush,
  output logic                       mem_valid,
  output logic [int_pkg::addr_w-1:0] mem_addr,
  output logic                       fetch_load,
  output logic [int_pkg::addr_w-1:0] new_eip,
  output logic [int_pkg::sel_w-1:0]  new_cs,
  output int_pkg::frame_t            ret_frame,
  output logic                       int_ack,
  output logic [int_pkg::vec_w-1:0]  ack_vector,
  output logic                       busy
);

  import int_pkg::*;

  logic                 pending;
  logic [vec_w-1:0]     vector;
  logic                 int_clear;
  logic                 addrp1;
  logic                 capture_bottom_eip;
  logic                 reg_load_cs;

  int_pending #(
    .NUM_LINES(NUM_LINES),
    .VEC_BASE (VEC_BASE)
  ) int_pending_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .int_line (int_line),
    .int_clear(int_clear),
    .lock     (busy),
    .pending  (pending),
    .vector   (vector),
    .line_sel ()
  );

  int_seq_ctrl int_seq_ctrl_i (
    .clk               (clk),
    .rst_n             (rst_n),
    .pending           (pending),
    .mem_ready         (mem_ready),
    .flush             (flush),
    .mem_valid         (mem_valid),
    .addrp1            (addrp1),
    .capture_bottom_eip(capture_bottom_eip),
    .reg_load_cs       (reg_load_cs),
    .fetch_load        (fetch_load),
    .int_clear         (int_clear),
    .busy              (busy)
  );

  int_frame_unit #(
    .IDT_BASE(IDT_BASE)
  ) int_frame_unit_i (
    .clk               (clk),
    .rst_n             (rst_n),
    .vector            (vector),
    .mem_valid         (mem_valid),
    .addrp1            (addrp1),
    .mem_ready         (mem_ready),
    .mem_rdata         (mem_rdata),
    .capture_bottom_eip(capture_bottom_eip),
    .bottom_eip        (bottom_eip),
    .cur_cs            (cur_cs),
    .reg_load_cs       (reg_load_cs),
    .mem_addr          (mem_addr),
    .new_eip           (new_eip),
    .new_cs            (new_cs),
    .ret_frame         (ret_frame)
  );

  assign int_ack = int_clear;  // Same strobe as the pending clear.
  assign ack_vector = vector;

endmodule

//--- testbench/tb_int_entry.sv
`timescale 1ns/1ps

module tb_int_entry;

  import int_pkg::*;

  localparam int num_lines = 8;
  localparam int vec_base = 32;
  localparam logic [addr_w-1:0] idt_base = 32'h0000_1000;
  localparam int clk_period = 20;
  localparam int num_tests = 5;
  localparam int mem_words = 512;

  logic                 clk;
  logic                 rst_n;
  logic [num_lines-1:0] int_line;
  logic [addr_w-1:0]    bottom_eip;
  logic [sel_w-1:0]     cur_cs;
  logic [addr_w-1:0]    mem_rdata;
  logic                 mem_ready;
  flush_t               flush;
  logic                 mem_valid;
  logic [addr_w-1:0]    mem_addr;
  logic                 fetch_load;
  logic [addr_w-1:0]    new_eip;
  logic [sel_w-1:0]     new_cs;
  frame_t               ret_frame;
  logic                 int_ack;
  logic [vec_w-1:0]     ack_vector;
  logic                 busy;

  logic [addr_w-1:0] mem [0:mem_words-1];  // Descriptor table image.
  logic [addr_w-1:0] addr_log[$];
  flush_t            flush_log[$];
  frame_t            target_log[$];
  frame_t            frame_log[$];
  frame_t            capture_log[$];
  logic [vec_w-1:0]  ack_log[$];
  int                value_errs = 0;
  int                event_errs = 0;
  int                fix_delay = 0;
  bit                rand_delay = 1'b0;
  integer            seed = 32'h267e;

  int_entry #(
    .NUM_LINES(num_lines),
    .VEC_BASE (vec_base),
    .IDT_BASE (idt_base)
  ) int_entry_i (
    .clk(clk), .rst_n(rst_n), .int_line(int_line), .bottom_eip(bottom_eip),
    .cur_cs(cur_cs), .mem_rdata(mem_rdata), .mem_ready(mem_ready), .flush(flush),
    .mem_valid(mem_valid), .mem_addr(mem_addr), .fetch_load(fetch_load),
    .new_eip(new_eip), .new_cs(new_cs), .ret_frame(ret_frame), .int_ack(int_ack),
    .ack_vector(ack_vector), .busy(busy)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  // Bottom of the pipe moves on every cycle.
  initial begin
    int cyc;
    cyc = 0;
    bottom_eip = 32'h0040_0000;
    cur_cs = 16'h0008;
    forever begin
      @(posedge clk);
      #2;
      cyc++;
      bottom_eip = 32'h0040_0000 + (addr_w'(cyc) << 2);
      cur_cs = 16'h0008 ^ sel_w'(cyc);
    end
  end

  function automatic logic [addr_w-1:0] read_mem(input logic [addr_w-1:0] addr);
    logic [addr_w-1:0] idx;
    idx = (addr - idt_base) >> 2;
    if (idx < addr_w'(mem_words)) begin
      return mem[idx[8:0]];
    end else begin
      return 32'hdead_beef;
    end
  endfunction

  // Memory model, one wait count per request.
  initial begin
    int  wait_left;
    bit  req_open;
    logic [addr_w-1:0] a;
    mem_ready = 1'b0;
    mem_rdata = '0;
    req_open = 1'b0;
    wait_left = 0;
    for (int i = 0; i < mem_words; i++) begin
      a = idt_base + addr_w'(i) * 32'd4;
      mem[i] = (a * 32'h9e37_79b1) ^ 32'h0bad_c0de;
    end
    forever begin
      @(posedge clk);
      #2;
      if (mem_ready) begin
        mem_ready = 1'b0;  // Transfer done at this edge.
        req_open = 1'b0;
      end
      if (mem_valid) begin
        if (!req_open) begin
          req_open = 1'b1;
          wait_left = rand_delay ? int'($unsigned($random(seed)) % 6) : fix_delay;
        end
        if (wait_left == 0) begin
          mem_ready = 1'b1;
          mem_rdata = read_mem(mem_addr);
        end else begin
          wait_left--;
        end
      end
    end
  end

  initial begin
    #((num_tests * 200 + 100) * clk_period);
    $display("Watchdog expired before the tests finished");
    $display("TB FAILED");
    $finish;
  end

  task automatic missing(input string msg);
    $display("%s (time %0t)", msg, $time);
    event_errs++;
  endtask

  task automatic check_flush(input flush_t got, input flush_t exp, input string what);
    if (got !== exp) begin
      $display("Fail %0t: %s got %b expected %b", $time, what, got, exp);
      value_errs++;
    end
  endtask

  task automatic check_frame(input frame_t got, input frame_t exp, input string what);
    if (got !== exp) begin
      $display("Fail %0t: %s got %h:%h expected %h:%h", $time, what,
               got.cs, got.eip, exp.cs, exp.eip);
      value_errs++;
    end
  endtask

  task automatic check_word(input logic [addr_w-1:0] got, input logic [addr_w-1:0] exp,
                            input string what);
    if (got !== exp) begin
      $display("Fail %0t: %s got %h expected %h", $time, what, got, exp);
      value_errs++;
    end
  endtask

  task automatic check_vec(input logic [vec_w-1:0] got, input logic [vec_w-1:0] exp,
                           input string what);
    if (got !== exp) begin
      $display("Fail %0t: %s got %0d expected %0d", $time, what, got, exp);
      value_errs++;
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("Fail %0t: %s got %b expected %b", $time, what, got, exp);
      value_errs++;
    end
  endtask

  // Samples at the falling edge, where outputs are settled.
  task automatic watch_bus();
    bit                cap_next;
    bit                prev_wait;
    logic [addr_w-1:0] prev_addr;
    frame_t            f;
    cap_next = 1'b0;
    prev_wait = 1'b0;
    prev_addr = '0;
    forever begin
      @(negedge clk);
      if (rst_n) begin
        if (cap_next) begin
          f.eip = bottom_eip;
          f.cs = cur_cs;
          capture_log.push_back(f);
        end
        cap_next = (flush == 7'h7f);  // CAPTURE follows FLUSH.
        if (flush != '0) flush_log.push_back(flush);
        if (prev_wait && !mem_valid) missing("mem_valid dropped before mem_ready");
        if (prev_wait && mem_valid) check_word(mem_addr, prev_addr, "mem_addr in wait state");
        if (mem_valid && mem_ready) addr_log.push_back(mem_addr);
        prev_wait = mem_valid && !mem_ready;
        prev_addr = mem_addr;
        if (fetch_load) begin
          f.eip = new_eip;
          f.cs = new_cs;
          target_log.push_back(f);
          frame_log.push_back(ret_frame);
        end
        if (int_ack) ack_log.push_back(ack_vector);
        // Every state but IDLE shows a flush bit or the load strobe.
        check_bit(busy, (flush != '0) || fetch_load, "busy");
      end
    end
  endtask

  initial watch_bus();

  task automatic clear_logs();
    addr_log.delete();
    flush_log.delete();
    target_log.delete();
    frame_log.delete();
    capture_log.delete();
    ack_log.delete();
  endtask

  task automatic pulse_lines(input logic [num_lines-1:0] mask);
    @(posedge clk);
    #2;
    int_line = mask;
    @(posedge clk);
    #2;
    int_line = '0;
  endtask

  task automatic wait_loads(input int n);
    int cycles;
    cycles = 0;
    while (target_log.size() < n && cycles < 100 * n) begin
      @(negedge clk);
      cycles++;
    end
    if (target_log.size() < n) missing($sformatf("only %0d of %0d fetch_load pulses seen",
                                                 target_log.size(), n));
  endtask

  // Gate and frame of the k-th entry since the logs were cleared.
  task automatic check_entry(input int k, input int line);
    logic [addr_w-1:0] lo;
    logic [addr_w-1:0] sel_word;
    frame_t            gate;
    lo = idt_base + addr_w'(vec_base + line) * 32'd8;
    if (addr_log.size() < 2 * k + 2 || target_log.size() <= k || ack_log.size() <= k ||
        capture_log.size() <= k) begin
      missing($sformatf("entry %0d for line %0d is incomplete", k, line));
    end else begin
      check_word(addr_log[2 * k], lo, "gate low address");
      check_word(addr_log[2 * k + 1], lo + 32'd4, "gate high address");
      sel_word = read_mem(lo + 32'd4);
      gate.eip = read_mem(lo);
      gate.cs = sel_word[sel_w-1:0];
      check_frame(target_log[k], gate, "new_eip:new_cs at fetch_load");
      check_frame(frame_log[k], capture_log[k], "ret_frame");
      check_vec(ack_log[k], vec_w'(vec_base + line), "ack_vector");
    end
  endtask

  task automatic test_reset();
    rst_n = 1'b0;
    repeat (9) begin
      @(posedge clk);
      @(negedge clk);
      check_flush(flush, '0, "flush in reset");
      check_word(addr_w'({mem_valid, fetch_load, int_ack, busy}), '0, "strobes in reset");
    end
    @(posedge clk);
    #2;
    rst_n = 1'b1;
    repeat (3) begin
      @(negedge clk);
      check_flush(flush, '0, "flush after reset");
      check_word(addr_w'({mem_valid, fetch_load, int_ack, busy}), '0, "strobes after reset");
    end
  endtask

  task automatic test_single();
    flush_t fetch_only;
    fetch_only = '0;
    fetch_only.fetch = 1'b1;
    fix_delay = 0;
    clear_logs();
    pulse_lines(num_lines'(1) << 3);
    wait_loads(1);
    check_entry(0, 3);
    if (flush_log.size() < 2) begin
      missing("flush cycles of the entry not seen");
    end else begin
      check_flush(flush_log[0], '1, "flush in FLUSH");
      check_flush(flush_log[1], fetch_only, "flush in CAPTURE");
    end
  endtask

  task automatic test_wait_states();
    rand_delay = 1'b1;
    repeat (3) begin
      clear_logs();
      pulse_lines(num_lines'(1) << 3);
      wait_loads(1);
      check_entry(0, 3);
    end
    rand_delay = 1'b0;
  endtask

  task automatic test_priority();
    fix_delay = 1;
    clear_logs();
    pulse_lines((num_lines'(1) << 5) | (num_lines'(1) << 2));
    wait_loads(2);
    check_entry(0, 2);
    check_entry(1, 5);
  endtask

  task automatic test_arrival();
    fix_delay = 2;
    clear_logs();
    pulse_lines(num_lines'(1) << 6);
    pulse_lines(num_lines'(1) << 1);  // Lands in FLUSH, vector already frozen.
    wait_loads(2);
    check_entry(0, 6);
    check_entry(1, 1);
  endtask

  initial begin
    rst_n = 1'b0;
    int_line = '0;
    test_reset();
    test_single();
    test_wait_states();
    test_priority();
    test_arrival();
    repeat (5) @(posedge clk);
    $display("Summary: %0d value errors, %0d missing events", value_errs, event_errs);
    if (value_errs == 0 && event_errs == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

//--- Makefile
SIM   := verilator
FLAGS := --binary --timing --assert -j 0
TOP   := tb_int_entry
FLIST := int_entry.f

SRCS := $(shell grep -v '^+' $(FLIST))
BIN  := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "TB PASSED"

clean:
	rm -rf obj_dir

//--- int_entry.f
design/int_pkg.sv
design/int_pending.sv
design/int_seq_ctrl.sv
design/int_frame_unit.sv
design/int_entry.sv
testbench/tb_int_entry.sv
